// ==== proc_config.svh ====
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Scalar register width
`define PROC_SCALAR_W 36

// Vector lanes and lane width
`define PROC_LANES 4
`define PROC_LANE_W 32
`define PROC_VEC_W (`PROC_LANES * `PROC_LANE_W)

// Register file depth, same for scalar and vector
`define PROC_NREGS 32
`define PROC_ADDR_W ($clog2(`PROC_NREGS))

// Instruction word
`define PROC_INST_W 32
`define PROC_OPCODE_W 6
`define PROC_IMM_W 16

// Register stages in the vector execute pipeline, at least 1
`define PROC_VEC_STAGES 3

`endif

// ==== proc_pkg.sv ====
`include "proc_config.svh"

package proc_pkg;

    // Instruction layout
    //   [31:26] opcode
    //   [24:20] rd
    //   [19:15] rs1
    //   [14:10] rs2
    //   [3:0]   lane mask, vector ops only
    //   [15:0]  imm16, LI and LUI only
    typedef enum logic [`PROC_OPCODE_W-1:0] {
        NOP   = 6'd0,
        ADD   = 6'd1,
        SUB   = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        XOR   = 6'd5,
        SHL   = 6'd6,
        LI    = 6'd7,
        LUI   = 6'd8,
        VADD  = 6'd9,
        VSUB  = 6'd10,
        VMUL  = 6'd11,
        VADDS = 6'd12
    } opcode_t;

    // Scalar write-back data source
    typedef enum logic [1:0] {
        ALU       = 2'd0,
        IMM       = 2'd1,
        IMM_UPPER = 2'd2
    } s_src_t;

    typedef struct packed {
        logic                      wr_en;
        logic [`PROC_ADDR_W-1:0]   wr_addr;
        s_src_t                    src;
        opcode_t                   alu_op;
        logic [`PROC_SCALAR_W-1:0] imm;  // imm16 already sign-extended
    } s_ctrl_t;

    typedef struct packed {
        logic                    wr_en;
        logic [`PROC_ADDR_W-1:0] wr_addr;
        logic [`PROC_LANES-1:0]  mask;
    } v_ctrl_t;

endpackage

// ==== delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t d,
    output payload_t q
);

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[DEPTH-1];

endmodule

// ==== decode.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module decode import proc_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [`PROC_INST_W-1:0]   inst,
    input  logic                      s_wr_en,
    input  logic [`PROC_ADDR_W-1:0]   s_wr_addr,
    input  logic [`PROC_SCALAR_W-1:0] s_wr_data,
    input  logic                      v_wr_en,
    input  logic [`PROC_ADDR_W-1:0]   v_wr_addr,
    input  logic [`PROC_LANES-1:0]    v_wr_mask,
    input  logic [`PROC_VEC_W-1:0]    v_wr_data,
    output logic [`PROC_SCALAR_W-1:0] s_op1,
    output logic [`PROC_SCALAR_W-1:0] s_op2,
    output s_ctrl_t                   s_ctrl,
    output logic [`PROC_VEC_W-1:0]    v_op1,
    output logic [`PROC_VEC_W-1:0]    v_op2,
    output logic [`PROC_LANE_W-1:0]   v_scalar,
    output opcode_t                   v_op,
    output v_ctrl_t                   v_ctrl,
    output logic                      err
);

    localparam int SW    = `PROC_SCALAR_W;
    localparam int LW    = `PROC_LANE_W;
    localparam int LANES = `PROC_LANES;
    localparam int AW    = `PROC_ADDR_W;
    localparam int IMM_W = `PROC_IMM_W;

    logic [SW-1:0]          s_rf [`PROC_NREGS];
    logic [`PROC_VEC_W-1:0] v_rf [`PROC_NREGS];

    opcode_t                opcode;
    logic [AW-1:0]          rd;
    logic [AW-1:0]          rs1;
    logic [AW-1:0]          rs2;
    logic [LANES-1:0]       mask;
    logic [IMM_W-1:0]       imm16;
    logic [SW-1:0]          s_rd1;
    logic [SW-1:0]          s_rd2;
    logic [`PROC_VEC_W-1:0] v_rd1;
    logic [`PROC_VEC_W-1:0] v_rd2;
    s_ctrl_t                s_ctrl_d;
    v_ctrl_t                v_ctrl_d;
    logic                   illegal;

    assign opcode = opcode_t'(inst[31:26]);
    assign rd     = inst[24:20];
    assign rs1    = inst[19:15];
    assign rs2    = inst[14:10];
    assign mask   = inst[3:0];
    assign imm16  = inst[15:0];

    // Register files, lanes written under the mask
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `PROC_NREGS; i++) begin
                s_rf[i] <= '0;
                v_rf[i] <= '0;
            end
        end else begin
            if (s_wr_en) begin
                s_rf[s_wr_addr] <= s_wr_data;
            end
            if (v_wr_en) begin
                for (int l = 0; l < LANES; l++) begin
                    if (v_wr_mask[l]) begin
                        v_rf[v_wr_addr][l*LW +: LW] <= v_wr_data[l*LW +: LW];
                    end
                end
            end
        end
    end

    // Write-through reads
    assign s_rd1 = (s_wr_en && s_wr_addr == rs1) ? s_wr_data : s_rf[rs1];
    assign s_rd2 = (s_wr_en && s_wr_addr == rs2) ? s_wr_data : s_rf[rs2];

    for (genvar l = 0; l < LANES; l++) begin : g_vread
        assign v_rd1[l*LW +: LW] = (v_wr_en && v_wr_mask[l] && v_wr_addr == rs1) ?
                                   v_wr_data[l*LW +: LW] : v_rf[rs1][l*LW +: LW];
        assign v_rd2[l*LW +: LW] = (v_wr_en && v_wr_mask[l] && v_wr_addr == rs2) ?
                                   v_wr_data[l*LW +: LW] : v_rf[rs2][l*LW +: LW];
    end

    always_comb begin
        s_ctrl_d = '0;
        v_ctrl_d = '0;
        illegal  = 1'b0;
        if (inst_valid) begin
            case (opcode)
                NOP: ;
                ADD, SUB, AND, OR, XOR, SHL: begin
                    s_ctrl_d.wr_en   = 1'b1;
                    s_ctrl_d.wr_addr = rd;
                    s_ctrl_d.src     = ALU;
                    s_ctrl_d.alu_op  = opcode;
                end
                LI, LUI: begin
                    s_ctrl_d.wr_en   = 1'b1;
                    s_ctrl_d.wr_addr = rd;
                    s_ctrl_d.src     = (opcode == LUI) ? IMM_UPPER : IMM;
                    s_ctrl_d.alu_op  = opcode;
                    s_ctrl_d.imm     = {{(SW-IMM_W){imm16[IMM_W-1]}}, imm16};
                end
                VADD, VSUB, VMUL, VADDS: begin
                    v_ctrl_d.wr_en   = 1'b1;
                    v_ctrl_d.wr_addr = rd;
                    v_ctrl_d.mask    = mask;
                end
                default: illegal = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_ctrl <= '0;
            v_ctrl <= '0;
            v_op   <= NOP;
            err    <= 1'b0;
        end else begin
            s_ctrl <= s_ctrl_d;
            v_ctrl <= v_ctrl_d;
            v_op   <= (inst_valid && !illegal) ? opcode : NOP;
            err    <= err | illegal;
        end
    end

    // Operands
    always_ff @(posedge clk) begin
        s_op1    <= s_rd1;
        s_op2    <= s_rd2;
        v_op1    <= v_rd1;
        v_op2    <= v_rd2;
        v_scalar <= s_rd2[LW-1:0];
    end

endmodule

// ==== scalar_execute.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module scalar_execute import proc_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PROC_SCALAR_W-1:0] op1,
    input  logic [`PROC_SCALAR_W-1:0] op2,
    input  s_ctrl_t                   ctrl,
    output logic [`PROC_SCALAR_W-1:0] result,
    output logic                      zero,
    output logic                      sign,
    output logic                      overflow
);

    localparam int W = `PROC_SCALAR_W;

    logic [W-1:0] alu_out;
    logic         ov;
    logic         is_alu;

    always_comb begin
        alu_out = '0;
        ov      = 1'b0;
        is_alu  = 1'b1;
        case (ctrl.alu_op)
            ADD: begin
                alu_out = op1 + op2;
                ov      = (op1[W-1] == op2[W-1]) && (alu_out[W-1] != op1[W-1]);
            end
            SUB: begin
                alu_out = op1 - op2;
                ov      = (op1[W-1] != op2[W-1]) && (alu_out[W-1] != op1[W-1]);
            end
            AND:     alu_out = op1 & op2;
            OR:      alu_out = op1 | op2;
            XOR:     alu_out = op1 ^ op2;
            SHL:     alu_out = op1 << op2[5:0];
            default: is_alu = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        result <= alu_out;
    end

    // Flags hold across immediates, NOPs and vector ops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            zero     <= 1'b0;
            sign     <= 1'b0;
            overflow <= 1'b0;
        end else if (ctrl.wr_en && is_alu) begin
            zero     <= (alu_out == '0);
            sign     <= alu_out[W-1];
            overflow <= ov;
        end
    end

endmodule

// ==== vector_execute.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module vector_execute import proc_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  opcode_t                 op,
    input  logic [`PROC_VEC_W-1:0]  op1,
    input  logic [`PROC_VEC_W-1:0]  op2,
    input  logic [`PROC_LANE_W-1:0] scalar,
    output logic [`PROC_VEC_W-1:0]  result
);

    localparam int LANES  = `PROC_LANES;
    localparam int LW     = `PROC_LANE_W;
    localparam int HW     = LW / 2;
    localparam int STAGES = `PROC_VEC_STAGES;
    localparam int TAIL   = (STAGES > 2) ? STAGES - 2 : 0;

    opcode_t s1_op;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_op <= NOP;
        end else begin
            s1_op <= op;
        end
    end

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        logic [LW-1:0] a;
        logic [LW-1:0] b;
        logic [LW-1:0] sum_d;
        logic [LW-1:0] s1_a;
        logic [LW-1:0] s1_b;
        logic [LW-1:0] s1_sum;
        logic [LW-1:0] pp_ll;
        logic [HW-1:0] pp_cross;
        logic [LW-1:0] lane_out;

        // Broadcast scalar replaces the second operand for VADDS
        assign a     = op1[l*LW +: LW];
        assign b     = (op == VADDS) ? scalar : op2[l*LW +: LW];
        assign sum_d = (op == VSUB) ? a - b : a + b;

        always_ff @(posedge clk) begin
            s1_a   <= a;
            s1_b   <= b;
            s1_sum <= sum_d;
        end

        // Low half of the product needs only three 16x16 pieces
        assign pp_ll    = s1_a[HW-1:0] * s1_b[HW-1:0];
        assign pp_cross = HW'(s1_a[HW-1:0] * s1_b[LW-1:HW] + s1_a[LW-1:HW] * s1_b[HW-1:0]);

        if (STAGES == 1) begin : g_comb_mul
            assign lane_out = (s1_op == VMUL) ? pp_ll + {pp_cross, {HW{1'b0}}} : s1_sum;
        end else begin : g_reg_mul
            logic [LW-1:0] s2_ll;
            logic [HW-1:0] s2_cross;
            logic [LW-1:0] s2_sum;
            logic          s2_mul;

            always_ff @(posedge clk) begin
                s2_ll    <= pp_ll;
                s2_cross <= pp_cross;
                s2_sum   <= s1_sum;
                s2_mul   <= (s1_op == VMUL);
            end

            assign lane_out = s2_mul ? s2_ll + {s2_cross, {HW{1'b0}}} : s2_sum;
        end

        if (TAIL == 0) begin : g_no_tail
            assign result[l*LW +: LW] = lane_out;
        end else begin : g_tail
            logic [LW-1:0] tail_q [TAIL];

            always_ff @(posedge clk) begin
                tail_q[0] <= lane_out;
                for (int i = 1; i < TAIL; i++) begin
                    tail_q[i] <= tail_q[i-1];
                end
            end

            assign result[l*LW +: LW] = tail_q[TAIL-1];
        end
    end

endmodule

// ==== writeback.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module writeback import proc_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  s_ctrl_t                   s_ctrl,
    input  logic [`PROC_SCALAR_W-1:0] alu_result,
    input  v_ctrl_t                   v_ctrl,
    input  logic [`PROC_VEC_W-1:0]    v_result,
    output logic                      s_wr_en,
    output logic [`PROC_ADDR_W-1:0]   s_wr_addr,
    output logic [`PROC_SCALAR_W-1:0] s_wr_data,
    output logic                      v_wr_en,
    output logic [`PROC_ADDR_W-1:0]   v_wr_addr,
    output logic [`PROC_LANES-1:0]    v_wr_mask,
    output logic [`PROC_VEC_W-1:0]    v_wr_data
);

    localparam int IMM_W = `PROC_IMM_W;

    logic [`PROC_SCALAR_W-1:0] s_data;

    // LUI puts imm16 just below bit 32
    always_comb begin
        s_data = alu_result;
        case (s_ctrl.src)
            IMM: s_data = s_ctrl.imm;
            IMM_UPPER: begin
                s_data = '0;
                s_data[2*IMM_W-1:IMM_W] = s_ctrl.imm[IMM_W-1:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s_wr_en   <= 1'b0;
            s_wr_addr <= '0;
            v_wr_en   <= 1'b0;
            v_wr_addr <= '0;
            v_wr_mask <= '0;
        end else begin
            s_wr_en   <= s_ctrl.wr_en;
            s_wr_addr <= s_ctrl.wr_addr;
            v_wr_en   <= v_ctrl.wr_en;
            v_wr_addr <= v_ctrl.wr_addr;
            v_wr_mask <= v_ctrl.mask;
        end
    end

    always_ff @(posedge clk) begin
        s_wr_data <= s_data;
        v_wr_data <= v_result;
    end

endmodule

// ==== proc.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module proc import proc_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      inst_valid,
    input  logic [`PROC_INST_W-1:0]   inst,
    output logic                      s_wr_en,
    output logic [`PROC_ADDR_W-1:0]   s_wr_addr,
    output logic [`PROC_SCALAR_W-1:0] s_wr_data,
    output logic                      v_wr_en,
    output logic [`PROC_ADDR_W-1:0]   v_wr_addr,
    output logic [`PROC_LANES-1:0]    v_wr_mask,
    output logic [`PROC_VEC_W-1:0]    v_wr_data,
    output logic                      zero,
    output logic                      sign,
    output logic                      overflow,
    output logic                      err
);

    logic [`PROC_SCALAR_W-1:0] s_op1;
    logic [`PROC_SCALAR_W-1:0] s_op2;
    logic [`PROC_SCALAR_W-1:0] alu_result;
    logic [`PROC_VEC_W-1:0]    v_op1;
    logic [`PROC_VEC_W-1:0]    v_op2;
    logic [`PROC_VEC_W-1:0]    v_result;
    logic [`PROC_LANE_W-1:0]   v_scalar;
    opcode_t                   v_op;
    s_ctrl_t                   s_ctrl_ex;
    s_ctrl_t                   s_ctrl_wb;
    v_ctrl_t                   v_ctrl_ex;
    v_ctrl_t                   v_ctrl_wb;

    decode u_decode (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
        .s_wr_en(s_wr_en), .s_wr_addr(s_wr_addr), .s_wr_data(s_wr_data),
        .v_wr_en(v_wr_en), .v_wr_addr(v_wr_addr), .v_wr_mask(v_wr_mask),
        .v_wr_data(v_wr_data), .s_op1(s_op1), .s_op2(s_op2), .s_ctrl(s_ctrl_ex),
        .v_op1(v_op1), .v_op2(v_op2), .v_scalar(v_scalar), .v_op(v_op),
        .v_ctrl(v_ctrl_ex), .err(err)
    );

    scalar_execute u_scalar_execute (
        .clk(clk), .rst_n(rst_n), .op1(s_op1), .op2(s_op2), .ctrl(s_ctrl_ex),
        .result(alu_result), .zero(zero), .sign(sign), .overflow(overflow)
    );

    vector_execute u_vector_execute (
        .clk(clk), .rst_n(rst_n), .op(v_op), .op1(v_op1), .op2(v_op2),
        .scalar(v_scalar), .result(v_result)
    );

    // Control words follow their data to write-back
    delay_line #(.payload_t(s_ctrl_t), .DEPTH(1)) u_s_ctrl_dly (
        .clk(clk), .rst_n(rst_n), .d(s_ctrl_ex), .q(s_ctrl_wb)
    );

    delay_line #(.payload_t(v_ctrl_t), .DEPTH(`PROC_VEC_STAGES)) u_v_ctrl_dly (
        .clk(clk), .rst_n(rst_n), .d(v_ctrl_ex), .q(v_ctrl_wb)
    );

    writeback u_writeback (
        .clk(clk), .rst_n(rst_n), .s_ctrl(s_ctrl_wb), .alu_result(alu_result),
        .v_ctrl(v_ctrl_wb), .v_result(v_result), .s_wr_en(s_wr_en),
        .s_wr_addr(s_wr_addr), .s_wr_data(s_wr_data), .v_wr_en(v_wr_en),
        .v_wr_addr(v_wr_addr), .v_wr_mask(v_wr_mask), .v_wr_data(v_wr_data)
    );

endmodule

// ==== proc_tb.sv ====
`timescale 1ns/1ps
`include "proc_config.svh"

module proc_tb import proc_pkg::*; ();

    localparam int SW      = `PROC_SCALAR_W;
    localparam int LW      = `PROC_LANE_W;
    localparam int LANES   = `PROC_LANES;
    localparam int VW      = `PROC_VEC_W;
    localparam int AW      = `PROC_ADDR_W;
    localparam int TIMEOUT = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 inst_valid;
    logic [31:0]          inst;
    logic                 s_wr_en;
    logic [AW-1:0]        s_wr_addr;
    logic [SW-1:0]        s_wr_data;
    logic                 v_wr_en;
    logic [AW-1:0]        v_wr_addr;
    logic [LANES-1:0]     v_wr_mask;
    logic [VW-1:0]        v_wr_data;
    logic                 zero;
    logic                 sign;
    logic                 overflow;
    logic                 err;

    // Reference model of both register files and the flags
    logic [SW-1:0]        s_model [`PROC_NREGS];
    logic [VW-1:0]        v_model [`PROC_NREGS];
    logic                 zero_m;
    logic                 sign_m;
    logic                 ov_m;
    string                cur_test;

    proc dut0 (
        .clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst(inst),
        .s_wr_en(s_wr_en), .s_wr_addr(s_wr_addr), .s_wr_data(s_wr_data),
        .v_wr_en(v_wr_en), .v_wr_addr(v_wr_addr), .v_wr_mask(v_wr_mask),
        .v_wr_data(v_wr_data), .zero(zero), .sign(sign), .overflow(overflow),
        .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_error();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string what, logic [VW-1:0] exp, logic [VW-1:0] act);
        $display("** Error in %s: %s expected %0h, actual %0h", cur_test, what, exp, act);
        stop_with_error();
    endtask

    function automatic logic [31:0] enc_reg(opcode_t op, int rd, int rs1, int rs2,
                                            logic [LANES-1:0] mask);
        logic [31:0] w;
        w        = '0;
        w[31:26] = op;
        w[24:20] = rd[4:0];
        w[19:15] = rs1[4:0];
        w[14:10] = rs2[4:0];
        w[3:0]   = mask;
        return w;
    endfunction

    function automatic logic [31:0] enc_imm(opcode_t op, int rd, logic [15:0] imm);
        return {op, 1'b0, rd[4:0], 4'h0, imm};
    endfunction

    function automatic logic [SW-1:0] imm_value(opcode_t op, logic [15:0] imm);
        if (op == LUI) begin
            return {{(SW-32){1'b0}}, imm, 16'h0};
        end
        return {{(SW-16){imm[15]}}, imm};
    endfunction

    // Result with the overflow of a 37-bit signed sum on top
    function automatic logic [SW:0] alu_model(opcode_t op, logic [SW-1:0] a, logic [SW-1:0] b);
        logic [SW:0]   wide;
        logic [SW-1:0] r;
        logic          ov;
        wide = '0;
        r    = '0;
        ov   = 1'b0;
        case (op)
            ADD: begin
                wide = {a[SW-1], a} + {b[SW-1], b};
                r    = wide[SW-1:0];
                ov   = wide[SW] ^ wide[SW-1];
            end
            SUB: begin
                wide = {a[SW-1], a} - {b[SW-1], b};
                r    = wide[SW-1:0];
                ov   = wide[SW] ^ wide[SW-1];
            end
            AND:     r = a & b;
            OR:      r = a | b;
            XOR:     r = a ^ b;
            SHL:     r = a << b[5:0];
            default: r = '0;
        endcase
        return {ov, r};
    endfunction

    function automatic logic [VW-1:0] vec_expect(opcode_t op, int rs1, int rs2);
        logic [VW-1:0]   r;
        logic [LW-1:0]   a;
        logic [LW-1:0]   b;
        logic [2*LW-1:0] prod;
        r = '0;
        for (int l = 0; l < LANES; l++) begin
            a = v_model[rs1][l*LW +: LW];
            b = (op == VADDS) ? s_model[rs2][LW-1:0] : v_model[rs2][l*LW +: LW];
            prod = a * b;
            case (op)
                VSUB:    r[l*LW +: LW] = a - b;
                VMUL:    r[l*LW +: LW] = prod[LW-1:0];
                default: r[l*LW +: LW] = a + b;
            endcase
        end
        return r;
    endfunction

    task automatic issue(logic [31:0] word);
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= word;
    endtask

    task automatic idle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= '0;
    endtask

    task automatic wait_scalar_write();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!s_wr_en && n < TIMEOUT);
        assert (s_wr_en) else begin
            $display("Timeout in %s: no scalar write within %0d cycles", cur_test, TIMEOUT);
            stop_with_error();
        end
    endtask

    task automatic wait_vector_write();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!v_wr_en && n < TIMEOUT);
        assert (v_wr_en) else begin
            $display("Timeout in %s: no vector write within %0d cycles", cur_test, TIMEOUT);
            stop_with_error();
        end
    endtask

    task automatic compare_scalar_write(int rd, logic [SW-1:0] exp);
        assert (s_wr_addr == rd[AW-1:0]) else report_mismatch("s_wr_addr", rd, s_wr_addr);
        assert (s_wr_data == exp) else report_mismatch("s_wr_data", exp, s_wr_data);
    endtask

    task automatic compare_vector_write(int rd, logic [LANES-1:0] mask, logic [VW-1:0] exp);
        assert (v_wr_addr == rd[AW-1:0]) else report_mismatch("v_wr_addr", rd, v_wr_addr);
        assert (v_wr_mask == mask) else report_mismatch("v_wr_mask", mask, v_wr_mask);
        for (int l = 0; l < LANES; l++) begin
            if (mask[l]) begin
                assert (v_wr_data[l*LW +: LW] == exp[l*LW +: LW])
                    else report_mismatch($sformatf("v_wr_data lane %0d", l),
                                         exp[l*LW +: LW], v_wr_data[l*LW +: LW]);
            end
        end
    endtask

    task automatic check_flags();
        assert (zero == zero_m) else report_mismatch("zero", zero_m, zero);
        assert (sign == sign_m) else report_mismatch("sign", sign_m, sign);
        assert (overflow == ov_m) else report_mismatch("overflow", ov_m, overflow);
    endtask

    task automatic commit_alu(int rd, logic [SW:0] x);
        s_model[rd] = x[SW-1:0];
        zero_m      = (x[SW-1:0] == '0);
        sign_m      = x[SW-1];
        ov_m        = x[SW];
    endtask

    task automatic commit_vec(int rd, logic [LANES-1:0] mask, logic [VW-1:0] data);
        for (int l = 0; l < LANES; l++) begin
            if (mask[l]) begin
                v_model[rd][l*LW +: LW] = data[l*LW +: LW];
            end
        end
    endtask

    task automatic load_imm(opcode_t op, int rd, logic [15:0] imm);
        logic [SW-1:0] v;
        v = imm_value(op, imm);
        issue(enc_imm(op, rd, imm));
        idle();
        wait_scalar_write();
        compare_scalar_write(rd, v);
        s_model[rd] = v;
        check_flags();
    endtask

    task automatic run_alu(opcode_t op, int rd, int rs1, int rs2);
        logic [SW:0] x;
        x = alu_model(op, s_model[rs1], s_model[rs2]);
        issue(enc_reg(op, rd, rs1, rs2, '0));
        idle();
        wait_scalar_write();
        compare_scalar_write(rd, x[SW-1:0]);
        commit_alu(rd, x);
        check_flags();
    endtask

    task automatic run_vec(opcode_t op, int rd, int rs1, int rs2, logic [LANES-1:0] mask);
        logic [VW-1:0] x;
        x = vec_expect(op, rs1, rs2);
        issue(enc_reg(op, rd, rs1, rs2, mask));
        idle();
        wait_vector_write();
        compare_vector_write(rd, mask, x);
        commit_vec(rd, mask, x);
        check_flags();
    endtask

    // Random 32-bit pattern in rd through scratch register tmp
    task automatic load_random(int rd, int tmp);
        load_imm(LUI, rd, 16'($urandom));
        load_imm(LI, tmp, 16'($urandom));
        run_alu(XOR, rd, rd, tmp);
    endtask

    task automatic reset_and_immediates();
        cur_test = "reset_and_immediates";
        @(negedge clk);
        assert ({s_wr_en, v_wr_en, err, zero, sign, overflow} == 6'b0)
            else report_mismatch("status after reset", 6'b0,
                                 {s_wr_en, v_wr_en, err, zero, sign, overflow});
        for (int k = 0; k < 4; k++) begin
            load_imm(LI, $urandom_range(1, 29), 16'($urandom));
            load_imm(LUI, $urandom_range(1, 29), 16'($urandom));
        end
    endtask

    task automatic scalar_alu();
        cur_test = "scalar_alu";
        load_random(1, 31);
        load_random(3, 31);
        load_imm(LI, 4, 16'($urandom));
        run_alu(ADD, 5, 1, 3);
        run_alu(SUB, 6, 1, 3);
        run_alu(AND, 7, 1, 4);
        run_alu(OR, 8, 3, 4);
        run_alu(XOR, 9, 1, 4);
        run_alu(SHL, 10, 1, 4);
        // Most negative value followed by signed overflow and a zero result
        load_imm(LI, 11, 16'd1);
        load_imm(LI, 12, 16'd35);
        run_alu(SHL, 13, 11, 12);
        run_alu(SUB, 14, 13, 11);
        run_alu(ADD, 15, 13, 13);
        run_alu(XOR, 16, 1, 1);
    endtask

    task automatic vector_arith();
        cur_test = "vector_arith";
        for (int k = 0; k < LANES; k++) begin
            load_random(20 + k, 31);
        end
        // One lane at a time from the zero register v0
        for (int l = 0; l < LANES; l++) begin
            run_vec(VADDS, 1, 0, 20 + l, LANES'(1 << l));
            run_vec(VADDS, 2, 0, 23 - l, LANES'(1 << l));
        end
        run_vec(VADD, 3, 1, 2, '1);
        run_vec(VSUB, 4, 1, 2, '1);
        run_vec(VMUL, 5, 1, 2, '1);
    endtask

    task automatic lane_masking();
        logic [LANES-1:0] mask;
        cur_test = "lane_masking";
        mask = LANES'($urandom_range(1, 14));
        run_vec(VADD, 6, 1, 2, '1);
        run_vec(VSUB, 6, 3, 5, mask);
        // Scalar r0 is never written
        run_vec(VADDS, 7, 6, 0, '1);
    endtask

    task automatic back_to_back();
        logic [SW:0]   sx;
        logic [VW-1:0] vx;
        logic [SW-1:0] px;
        logic [15:0]   imm;
        cur_test = "back_to_back";
        sx = alu_model(ADD, s_model[1], s_model[3]);
        vx = vec_expect(VADD, 1, 2);
        issue(enc_reg(ADD, 17, 1, 3, '0));
        issue(enc_reg(VADD, 8, 1, 2, '1));
        idle();
        wait_scalar_write();
        compare_scalar_write(17, sx[SW-1:0]);
        commit_alu(17, sx);
        check_flags();
        wait_vector_write();
        compare_vector_write(8, '1, vx);
        commit_vec(8, '1, vx);

        // Consumer issued on the producer's s_wr_en cycle
        imm = 16'($urandom);
        px  = imm_value(LI, imm);
        s_model[18] = px;
        sx = alu_model(ADD, s_model[18], s_model[1]);
        issue(enc_imm(LI, 18, imm));
        repeat (2) idle();
        issue(enc_reg(ADD, 19, 18, 1, '0));
        wait_scalar_write();
        compare_scalar_write(18, px);
        idle();
        wait_scalar_write();
        compare_scalar_write(19, sx[SW-1:0]);
        commit_alu(19, sx);
        check_flags();

        // Same on the vector side
        vx = vec_expect(VADDS, 0, 19);
        commit_vec(9, '1, vx);
        issue(enc_reg(VADDS, 9, 0, 19, '1));
        repeat (`PROC_VEC_STAGES + 1) idle();
        issue(enc_reg(VMUL, 10, 9, 1, '1));
        wait_vector_write();
        compare_vector_write(9, '1, vx);
        vx = vec_expect(VMUL, 9, 1);
        idle();
        wait_vector_write();
        compare_vector_write(10, '1, vx);
        commit_vec(10, '1, vx);
    endtask

    task automatic illegal_opcode();
        cur_test = "illegal_opcode";
        assert (err == 1'b0) else report_mismatch("err before illegal opcode", 1'b0, err);
        issue({6'h3f, 1'b0, 5'd12, 20'h0});
        idle();
        @(negedge clk);
        assert (err == 1'b1) else report_mismatch("err", 1'b1, err);
        repeat (8) begin
            @(negedge clk);
            assert (err == 1'b1) else report_mismatch("err", 1'b1, err);
            assert (!s_wr_en && !v_wr_en) else begin
                $display("%s: a write pulse followed the illegal instruction", cur_test);
                stop_with_error();
            end
        end
    endtask

    initial begin
        void'($urandom(32'h2d0c_ac00));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        zero_m     = 1'b0;
        sign_m     = 1'b0;
        ov_m       = 1'b0;
        for (int i = 0; i < `PROC_NREGS; i++) begin
            s_model[i] = '0;
            v_model[i] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        reset_and_immediates();
        scalar_alu();
        vector_arith();
        lane_masking();
        back_to_back();
        illegal_opcode();

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
proc_pkg.sv
delay_line.sv
decode.sv
scalar_execute.sv
vector_execute.sv
writeback.sv
proc.sv
proc_tb.sv

// ==== Bender.yml ====
package:
  name: proc

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - proc_pkg.sv
      - delay_line.sv
      - decode.sv
      - scalar_execute.sv
      - vector_execute.sv
      - writeback.sv
      - proc.sv
  - target: test
    include_dirs:
      - .
    files:
      - proc_tb.sv
